// File: Bender.yml
package:
  name: fe_fetch

sources:
  - files:
      - source/mem_types_pkg.sv
      - source/fe_types_pkg.sv
      - source/fb_entry_if.sv
      - source/fe_fb_entry.sv
      - source/fe_pf.sv
      - source/fe_buf.sv
      - source/fe_fetch_top.sv

  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_fe_fetch.sv

// File: compile.f
+incdir+sim
source/mem_types_pkg.sv
source/fe_types_pkg.sv
source/fb_entry_if.sv
source/fe_fb_entry.sv
source/fe_pf.sv
source/fe_buf.sv
source/fe_fetch_top.sv
sim/tb_fe_fetch.sv

// File: sim/fb_ref_model.svh
`ifndef FB_REF_MODEL_SVH
`define FB_REF_MODEL_SVH

localparam int NUM_IDS = 1 << FE_ID_W;

// Outstanding front-end requests, indexed by id
logic   sb_busy [NUM_IDS];
t_paddr sb_pc   [NUM_IDS];
int     sb_cnt;

function automatic t_paddr line_base(input t_paddr addr);
    return addr & ~t_paddr'(CL_BYTES - 1);
endfunction

function automatic int set_of(input t_paddr addr);
    return int'((addr >> CL_OFFS_W) & t_paddr'(FB_NUM_SETS - 1));
endfunction

// Memory image behind the IC, every word mixed from its full address
function automatic t_instr mem_word(input t_paddr addr);
    logic [31:0] a;
    logic [31:0] x;
    a = {addr[PADDR_W-1:2], 2'b00};
    x = a * 32'h9e37_79b1;
    x = x ^ (x >> 15);
    x = x ^ {a[15:0], a[31:16]};
    x = x * 32'h85eb_ca6b;
    return x ^ (x >> 13);
endfunction

// Word k of the line sits at bits 32k and up
function automatic t_cl mem_line(input t_paddr addr);
    t_paddr base;
    t_cl    cl;
    base = line_base(addr);
    for (int k = 0; k < CL_BYTES / 4; k++) begin
        cl[k*32 +: 32] = mem_word(base + t_paddr'(4 * k));
    end
    return cl;
endfunction

function automatic void sb_clear();
    for (int i = 0; i < NUM_IDS; i++) begin
        sb_busy[i] = 1'b0;
        sb_pc[i]   = '0;
    end
    sb_cnt = 0;
endfunction

function automatic void sb_add(input t_fe_id id, input t_paddr pc);
    sb_busy[id] = 1'b1;
    sb_pc[id]   = pc;
    sb_cnt++;
endfunction

function automatic void sb_retire(input t_fe_id id);
    sb_busy[id] = 1'b0;
    sb_cnt--;
endfunction

`endif

// File: sim/tb_fe_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fe_fetch
    import mem_types_pkg::*, fe_types_pkg::*;
();

    localparam int     RST_CYCLES  = 8;
    localparam int     N_RANDOM    = 590;
    localparam int     N_PF_CHECKS = 5;
    localparam int     N_REQ       = N_RANDOM + 2 * N_PF_CHECKS;
    localparam int     TIMEOUT_CYC = N_REQ * 20 + RST_CYCLES;
    localparam int     POOL_LINES  = 24;
    localparam t_paddr POOL_BASE   = 32'h0000_4000;
    localparam int     DRIVE_DLY   = 10;

    logic    clk;
    logic    rst_n;
    logic    fe_req_valid;
    t_fe_id  fe_req_id;
    t_paddr  fe_req_addr;
    logic    fe_rsp_valid;
    t_fe_id  fe_rsp_id;
    t_paddr  fe_rsp_pc;
    t_instr  fe_rsp_instr;
    logic    ic_req_valid;
    t_mem_id ic_req_id;
    t_paddr  ic_req_addr;
    logic    ic_rsp_valid;
    t_mem_id ic_rsp_id;
    t_cl     ic_rsp_data;

    `include "fb_ref_model.svh"

    // Line buffer contents as the front end sees them
    logic    mdl_vld [FB_NUM_SETS];
    t_paddr  mdl_tag [FB_NUM_SETS];
    t_paddr  fill_addr_q [$];
    int      fill_due_q  [$];

    // IC responder state
    t_mem_id ic_id_q   [$];
    t_paddr  ic_addr_q [$];
    int      ic_due_q  [$];
    logic    ic_out      [FB_NUM_ENTS];
    int      ent_free_at [FB_NUM_ENTS];

    logic    line_seen [POOL_LINES + 1];
    int      cyc;
    int      wd_cnt;
    int      issued;
    int      last_line;
    int      seed_init;
    logic    hit_due;
    t_fe_id  hit_id;

    fe_fetch_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .fe_req_valid (fe_req_valid),
        .fe_req_id    (fe_req_id),
        .fe_req_addr  (fe_req_addr),
        .fe_rsp_valid (fe_rsp_valid),
        .fe_rsp_id    (fe_rsp_id),
        .fe_rsp_pc    (fe_rsp_pc),
        .fe_rsp_instr (fe_rsp_instr),
        .ic_req_valid (ic_req_valid),
        .ic_req_id    (ic_req_id),
        .ic_req_addr  (ic_req_addr),
        .ic_rsp_valid (ic_rsp_valid),
        .ic_rsp_id    (ic_rsp_id),
        .ic_rsp_data  (ic_rsp_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "Simulation stopped at %0t ns", $time);
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR at %0t ns: %s = %b, expected %b", $time, name, got, exp));
        end
    endtask

    task automatic compare_instr(input string name, input t_instr got, input t_instr exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic compare_pc(input string name, input t_paddr got, input t_paddr exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic compare_id(input string name, input t_fe_id got, input t_fe_id exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR at %0t ns: %s = %0d, expected %0d", $time, name, got, exp));
        end
    endtask

    function automatic int line_index(input t_paddr addr);
        return int'((addr - POOL_BASE) >> CL_OFFS_W);
    endfunction

    function automatic t_paddr line_addr(input int li);
        return POOL_BASE + t_paddr'(li * CL_BYTES);
    endfunction

    // Entries known to hold an IC transaction or its fill cycle
    function automatic int ic_busy_count();
        int n;
        n = 0;
        for (int i = 0; i < FB_NUM_ENTS; i++) begin
            if (ic_out[i] || (cyc < ent_free_at[i])) begin
                n++;
            end
        end
        return n;
    endfunction

    // Keeps a free miss entry for the next demand miss
    function automatic logic can_issue();
        return !ic_req_valid && (sb_cnt < 3) && (sb_cnt + ic_busy_count() <= 3);
    endfunction

    function automatic t_fe_id pick_free_id();
        t_fe_id id;
        id = t_fe_id'($urandom_range(0, NUM_IDS - 1));
        while (sb_busy[id]) begin
            id = id + 1'b1;
        end
        return id;
    endfunction

    // Next line now and then so prefetched lines get used
    function automatic t_paddr random_addr();
        int li;
        if ((last_line < POOL_LINES - 1) && ($urandom_range(0, 2) == 0)) begin
            li = last_line + 1;
        end else begin
            li = $urandom_range(0, POOL_LINES - 1);
        end
        last_line = li;
        return line_addr(li) + t_paddr'(4 * $urandom_range(0, 3));
    endfunction

    task automatic check_fe_rsp();
        t_paddr exp_pc;
        if (hit_due) begin
            compare_flag("fe_rsp_valid", fe_rsp_valid, 1'b1);
            compare_id("fe_rsp_id", fe_rsp_id, hit_id);
            hit_due = 1'b0;
        end
        if (fe_rsp_valid) begin
            if (!sb_busy[fe_rsp_id]) begin
                abort_run($sformatf("Response with id %0d, which has no request outstanding",
                                    fe_rsp_id));
            end
            exp_pc = sb_pc[fe_rsp_id];
            compare_pc("fe_rsp_pc", fe_rsp_pc, exp_pc);
            compare_instr("fe_rsp_instr", fe_rsp_instr, mem_word(exp_pc));
            sb_retire(fe_rsp_id);
        end
    endtask

    task automatic check_ic_req();
        int li;
        if (ic_req_valid) begin
            if (ic_req_addr[CL_OFFS_W-1:0] != '0) begin
                abort_run($sformatf("IC request address %h is not line aligned",
                                    ic_req_addr));
            end
            if (ic_out[ic_req_id]) begin
                abort_run($sformatf("IC request reuses id %0d while it is still outstanding",
                                    ic_req_id));
            end
            li = line_index(ic_req_addr);
            if ((li > POOL_LINES) || !line_seen[li]) begin
                abort_run($sformatf("IC request for line %h, which no request led to",
                                    ic_req_addr));
            end
            ic_out[ic_req_id] = 1'b1;
            ic_id_q.push_back(ic_req_id);
            ic_addr_q.push_back(ic_req_addr);
            ic_due_q.push_back(cyc + $urandom_range(2, 12));
        end
    endtask

    // Answers at most one due request per cycle and picks the oldest
    task automatic answer_ic();
        int sel;
        sel = -1;
        for (int i = 0; i < ic_due_q.size(); i++) begin
            if ((sel < 0) && (ic_due_q[i] <= cyc)) begin
                sel = i;
            end
        end
        if (sel < 0) begin
            ic_rsp_valid = 1'b0;
            ic_rsp_id    = '0;
            ic_rsp_data  = '0;
        end else begin
            ic_rsp_valid = 1'b1;
            ic_rsp_id    = ic_id_q[sel];
            ic_rsp_data  = mem_line(ic_addr_q[sel]);
            ic_out[ic_id_q[sel]]      = 1'b0;
            ent_free_at[ic_id_q[sel]] = cyc + 2;
            // Line is hit-visible two cycles on
            fill_addr_q.push_back(ic_addr_q[sel]);
            fill_due_q.push_back(cyc + 2);
            ic_id_q.delete(sel);
            ic_addr_q.delete(sel);
            ic_due_q.delete(sel);
        end
    endtask

    // Advance one cycle, check outputs, serve the IC
    task automatic step();
        @(posedge clk);
        #DRIVE_DLY;
        cyc++;
        while (fill_due_q.size() > 0) begin
            if (fill_due_q[0] > cyc) begin
                break;
            end
            mdl_vld[set_of(fill_addr_q[0])] = 1'b1;
            mdl_tag[set_of(fill_addr_q[0])] = fill_addr_q[0];
            void'(fill_addr_q.pop_front());
            void'(fill_due_q.pop_front());
        end
        check_fe_rsp();
        check_ic_req();
        answer_ic();
    endtask

    task automatic drive_req(input t_paddr addr, output t_fe_id id);
        int li;
        int set;
        id  = pick_free_id();
        li  = line_index(addr);
        set = set_of(addr);
        fe_req_valid = 1'b1;
        fe_req_id    = id;
        fe_req_addr  = addr;
        sb_add(id, addr);
        line_seen[li]     = 1'b1;
        line_seen[li + 1] = 1'b1;
        if (mdl_vld[set] && (mdl_tag[set] == line_base(addr))) begin
            hit_due = 1'b1;
            hit_id  = id;
        end
    endtask

    task automatic drive_idle();
        fe_req_valid = 1'b0;
    endtask

    task automatic drain();
        do begin
            step();
            drive_idle();
        end while ((sb_cnt != 0) || (ic_busy_count() != 0) || ic_req_valid);
    endtask

    // Line A, idle time, then A plus one line must hit
    task automatic check_prefetch(input int li);
        t_fe_id id;
        step();
        drive_req(line_addr(li) + t_paddr'(4 * $urandom_range(0, 3)), id);
        repeat (8) begin
            step();
            drive_idle();
        end
        drain();
        step();
        drive_req(line_addr(li + 1) + t_paddr'(4 * $urandom_range(0, 3)), id);
        step();
        compare_flag("fe_rsp_valid", fe_rsp_valid, 1'b1);
        compare_id("fe_rsp_id", fe_rsp_id, id);
        drive_idle();
        drain();
    endtask

    initial begin
        wd_cnt = 0;
        forever begin
            @(posedge clk);
            wd_cnt++;
            if (wd_cnt > TIMEOUT_CYC) begin
                abort_run($sformatf("Timeout, run did not finish within %0d cycles",
                                    TIMEOUT_CYC));
            end
        end
    end

    initial begin
        t_fe_id id;
        seed_init    = $urandom(32'h92a1_dd15);
        rst_n        = 1'b0;
        fe_req_valid = 1'b0;
        fe_req_id    = '0;
        fe_req_addr  = '0;
        ic_rsp_valid = 1'b0;
        ic_rsp_id    = '0;
        ic_rsp_data  = '0;
        for (int i = 0; i < FB_NUM_SETS; i++) begin
            mdl_vld[i] = 1'b0;
            mdl_tag[i] = '0;
        end
        for (int i = 0; i < FB_NUM_ENTS; i++) begin
            ic_out[i]      = 1'b0;
            ent_free_at[i] = 0;
        end
        for (int i = 0; i <= POOL_LINES; i++) begin
            line_seen[i] = 1'b0;
        end
        sb_clear();
        cyc       = 0;
        hit_due   = 1'b0;
        last_line = 0;

        repeat (RST_CYCLES) begin
            @(posedge clk);
            #DRIVE_DLY;
            compare_flag("fe_rsp_valid", fe_rsp_valid, 1'b0);
            compare_flag("ic_req_valid", ic_req_valid, 1'b0);
        end
        rst_n = 1'b1;
        repeat (2) begin
            step();
            compare_flag("fe_rsp_valid", fe_rsp_valid, 1'b0);
            compare_flag("ic_req_valid", ic_req_valid, 1'b0);
            drive_idle();
        end

        issued = 0;
        while (issued < N_RANDOM) begin
            step();
            if (can_issue() && ($urandom_range(0, 99) < 70)) begin
                drive_req(random_addr(), id);
                issued++;
            end else begin
                drive_idle();
            end
        end
        drain();

        for (int n = 0; n < N_PF_CHECKS; n++) begin
            check_prefetch($urandom_range(0, POOL_LINES - 2));
        end

        if (sb_cnt == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            abort_run("Requests still outstanding at the end of the run");
        end
    end

endmodule

`default_nettype wire

// File: source/fb_entry_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fb_entry_if
    import mem_types_pkg::*, fe_types_pkg::*;
();

    // Buffer to entry
    logic        push;
    t_ent_static push_static;
    logic        ic_gn;
    t_mem_rsp    ic_rsp;
    logic        fe_gn;

    // Entry to buffer
    logic        busy;
    t_ent_static ent_static;
    logic        ic_rq;
    logic        fe_rq;
    t_fb_fe_rsp  fe_rsp_pkt;
    logic        fill;
    t_cl         fill_data;
    t_paddr      fill_addr;

    // Buffer side of the bundle
    modport fbuf (
        output push, push_static, ic_gn, ic_rsp, fe_gn,
        input  busy, ent_static, ic_rq, fe_rq, fe_rsp_pkt, fill, fill_data, fill_addr
    );

    modport ent (
        input  push, push_static, ic_gn, ic_rsp, fe_gn,
        output busy, ent_static, ic_rq, fe_rq, fe_rsp_pkt, fill, fill_data, fill_addr
    );

endinterface

`default_nettype wire

// File: source/fe_buf.sv
`timescale 1ns/1ps
`default_nettype none

module fe_buf
    import mem_types_pkg::*, fe_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  t_fe_fb_req fe_req,
    output t_fb_fe_rsp fe_rsp,
    output t_mem_req   ic_req,
    input  t_mem_rsp   ic_rsp
);

    typedef logic [FB_NUM_ENTS-1:0] t_ent_vec;

    // Lowest set bit as a one-hot vector
    function automatic t_ent_vec first_one(input t_ent_vec v);
        t_ent_vec oh;
        oh = '0;
        for (int i = FB_NUM_ENTS - 1; i >= 0; i--) begin
            if (v[i]) begin
                oh    = '0;
                oh[i] = 1'b1;
            end
        end
        return oh;
    endfunction

    function automatic logic [FB_NUM_ENTS_LG2-1:0] oh_enc(input t_ent_vec oh);
        logic [FB_NUM_ENTS_LG2-1:0] idx;
        idx = '0;
        for (int i = 0; i < FB_NUM_ENTS; i++) begin
            if (oh[i]) begin
                idx = FB_NUM_ENTS_LG2'(i);
            end
        end
        return idx;
    endfunction

    // Line buffer
    logic [FB_NUM_SETS-1:0] buf_vld;
    t_paddr                 buf_tag  [FB_NUM_SETS];
    t_cl                    buf_data [FB_NUM_SETS];

    t_setid      req_set;
    logic        hit;
    logic        miss;

    logic        pf_rq;
    t_paddr      pf_addr;
    logic        pf_gn;
    logic        pf_hit;
    logic        pf_held;
    logic        pf_alloc;

    t_ent_vec    busy_v;
    t_ent_vec    ic_rq_v;
    t_ent_vec    fe_rq_v;
    t_ent_vec    fill_v;
    t_ent_vec    push_v;
    t_ent_vec    ic_gn_v;
    t_ent_vec    fe_gn_v;
    t_ent_static stat_v      [FB_NUM_ENTS];
    t_fb_fe_rsp  fe_pkt_v    [FB_NUM_ENTS];
    t_cl         fill_data_v [FB_NUM_ENTS];
    t_paddr      fill_addr_v [FB_NUM_ENTS];
    t_ent_static push_static;
    t_fb_fe_rsp  rsp_nxt;

    logic [FB_NUM_ENTS_LG2-1:0] ic_sel;

    fb_entry_if e_if [FB_NUM_ENTS] ();

    assign req_set = get_setid(fe_req.addr);
    assign hit     = fe_req.valid && buf_vld[req_set] &&
                     (buf_tag[req_set] == cl_align(fe_req.addr));
    assign miss    = fe_req.valid && !hit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_vld <= '0;
        end else begin
            for (int i = 0; i < FB_NUM_ENTS; i++) begin
                if (fill_v[i]) begin
                    buf_vld[get_setid(fill_addr_v[i])] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < FB_NUM_ENTS; i++) begin
            if (fill_v[i]) begin
                buf_tag[get_setid(fill_addr_v[i])]  <= fill_addr_v[i];
                buf_data[get_setid(fill_addr_v[i])] <= fill_data_v[i];
            end
        end
    end

    fe_pf u_pf (
        .clk     (clk),
        .rst_n   (rst_n),
        .fe_req  (fe_req),
        .pf_rq   (pf_rq),
        .pf_addr (pf_addr),
        .pf_gn   (pf_gn)
    );

    // Skip proposals already in the buffer or in flight
    assign pf_hit = buf_vld[get_setid(pf_addr)] && (buf_tag[get_setid(pf_addr)] == pf_addr);

    always_comb begin
        pf_held = 1'b0;
        for (int i = 0; i < FB_NUM_ENTS; i++) begin
            if (busy_v[i] && (cl_align(stat_v[i].req.addr) == pf_addr)) begin
                pf_held = 1'b1;
            end
        end
    end

    assign pf_gn    = pf_rq && !miss;
    assign pf_alloc = pf_gn && !pf_hit && !pf_held;

    // Demand miss first, else the prefetch
    assign push_v = (miss || pf_alloc) ? first_one(~busy_v) : '0;

    always_comb begin
        push_static = '0;
        if (miss) begin
            push_static.req = fe_req;
            push_static.pf  = 1'b0;
        end else begin
            push_static.req.valid = 1'b1;
            push_static.req.addr  = pf_addr;
            push_static.pf        = 1'b1;
        end
    end

    for (genvar i = 0; i < FB_NUM_ENTS; i++) begin : g_ent
        assign e_if[i].push        = push_v[i];
        assign e_if[i].push_static = push_static;
        assign e_if[i].ic_gn       = ic_gn_v[i];
        assign e_if[i].ic_rsp      = ic_rsp;
        assign e_if[i].fe_gn       = fe_gn_v[i];

        assign busy_v[i]      = e_if[i].busy;
        assign stat_v[i]      = e_if[i].ent_static;
        assign ic_rq_v[i]     = e_if[i].ic_rq;
        assign fe_rq_v[i]     = e_if[i].fe_rq;
        assign fe_pkt_v[i]    = e_if[i].fe_rsp_pkt;
        assign fill_v[i]      = e_if[i].fill;
        assign fill_data_v[i] = e_if[i].fill_data;
        assign fill_addr_v[i] = e_if[i].fill_addr;

        fe_fb_entry u_ent (
            .clk     (clk),
            .rst_n   (rst_n),
            .ent     (e_if[i]),
            .ent_idx (t_mem_id'(i))
        );
    end

    // IC request, fixed priority
    assign ic_gn_v = first_one(ic_rq_v);
    assign ic_sel  = oh_enc(ic_gn_v);

    always_comb begin
        ic_req       = '0;
        ic_req.valid = |ic_rq_v;
        ic_req.id    = t_mem_id'(ic_sel);
        ic_req.addr  = cl_align(stat_v[ic_sel].req.addr);
    end

    // A hit takes the response slot over any entry
    assign fe_gn_v = hit ? '0 : first_one(fe_rq_v);

    always_comb begin
        rsp_nxt = '0;
        if (hit) begin
            rsp_nxt.valid = 1'b1;
            rsp_nxt.id    = fe_req.id;
            rsp_nxt.pc    = fe_req.addr;
            rsp_nxt.instr = instr_from_cl(buf_data[req_set], fe_req.addr);
        end else begin
            for (int i = 0; i < FB_NUM_ENTS; i++) begin
                if (fe_gn_v[i]) begin
                    rsp_nxt = fe_pkt_v[i];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fe_rsp <= '0;
        end else begin
            fe_rsp <= rsp_nxt;
        end
    end

endmodule

`default_nettype wire

// File: source/fe_fb_entry.sv
`timescale 1ns/1ps
`default_nettype none

module fe_fb_entry
    import mem_types_pkg::*, fe_types_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    fb_entry_if.ent ent,
    input  t_mem_id ent_idx
);

    t_ent_state  state;
    t_ent_static stat;
    t_cl         line;
    logic        fill_q;
    logic        rsp_hit;

    // Response is broadcast, pick out our own id
    assign rsp_hit = ent.ic_rsp.valid && (ent.ic_rsp.id == ent_idx) &&
                     (state == ENT_IC_WAIT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= ENT_IDLE;
            fill_q <= 1'b0;
        end else begin
            fill_q <= rsp_hit;
            case (state)
                ENT_IDLE: begin
                    if (ent.push) begin
                        state <= ENT_IC_REQ;
                    end
                end
                ENT_IC_REQ: begin
                    if (ent.ic_gn) begin
                        state <= ENT_IC_WAIT;
                    end
                end
                ENT_IC_WAIT: begin
                    // Prefetches only fill, no front-end response
                    if (rsp_hit) begin
                        state <= stat.pf ? ENT_IDLE : ENT_FE_RSP;
                    end
                end
                ENT_FE_RSP: begin
                    if (ent.fe_gn) begin
                        state <= ENT_IDLE;
                    end
                end
                default: state <= ENT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ent.push) begin
            stat <= ent.push_static;
        end
        if (rsp_hit) begin
            line <= ent.ic_rsp.data;
        end
    end

    // Stay busy through the fill cycle so no duplicate gets allocated
    assign ent.busy       = (state != ENT_IDLE) || fill_q;
    assign ent.ent_static = stat;
    assign ent.ic_rq      = (state == ENT_IC_REQ);
    assign ent.fe_rq      = (state == ENT_FE_RSP);

    always_comb begin
        ent.fe_rsp_pkt       = '0;
        ent.fe_rsp_pkt.valid = (state == ENT_FE_RSP);
        ent.fe_rsp_pkt.id    = stat.req.id;
        ent.fe_rsp_pkt.pc    = stat.req.addr;
        ent.fe_rsp_pkt.instr = instr_from_cl(line, stat.req.addr);
    end

    assign ent.fill      = fill_q;
    assign ent.fill_data = line;
    assign ent.fill_addr = cl_align(stat.req.addr);

endmodule

`default_nettype wire

// File: source/fe_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fe_fetch_top
    import mem_types_pkg::*, fe_types_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,

    // Front end
    input  logic    fe_req_valid,
    input  t_fe_id  fe_req_id,
    input  t_paddr  fe_req_addr,
    output logic    fe_rsp_valid,
    output t_fe_id  fe_rsp_id,
    output t_paddr  fe_rsp_pc,
    output t_instr  fe_rsp_instr,

    // Instruction cache
    output logic    ic_req_valid,
    output t_mem_id ic_req_id,
    output t_paddr  ic_req_addr,
    input  logic    ic_rsp_valid,
    input  t_mem_id ic_rsp_id,
    input  t_cl     ic_rsp_data
);

    t_fe_fb_req fe_req;
    t_fb_fe_rsp fe_rsp;
    t_mem_req   ic_req;
    t_mem_rsp   ic_rsp;

    always_comb begin
        fe_req.valid = fe_req_valid;
        fe_req.id    = fe_req_id;
        fe_req.addr  = fe_req_addr;
        ic_rsp.valid = ic_rsp_valid;
        ic_rsp.id    = ic_rsp_id;
        ic_rsp.data  = ic_rsp_data;
    end

    fe_buf u_buf (
        .clk    (clk),
        .rst_n  (rst_n),
        .fe_req (fe_req),
        .fe_rsp (fe_rsp),
        .ic_req (ic_req),
        .ic_rsp (ic_rsp)
    );

    assign fe_rsp_valid = fe_rsp.valid;
    assign fe_rsp_id    = fe_rsp.id;
    assign fe_rsp_pc    = fe_rsp.pc;
    assign fe_rsp_instr = fe_rsp.instr;
    assign ic_req_valid = ic_req.valid;
    assign ic_req_id    = ic_req.id;
    assign ic_req_addr  = ic_req.addr;

endmodule

`default_nettype wire

// File: source/fe_pf.sv
`timescale 1ns/1ps
`default_nettype none

module fe_pf
    import mem_types_pkg::*, fe_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  t_fe_fb_req fe_req,
    output logic       pf_rq,
    output t_paddr     pf_addr,
    input  logic       pf_gn
);

    t_paddr next_line;

    // Line after the current request
    assign next_line = cl_align(fe_req.addr) + t_paddr'(CL_BYTES);

    // A new request wins over a grant in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pf_rq <= 1'b0;
        end else if (fe_req.valid) begin
            pf_rq <= 1'b1;
        end else if (pf_gn) begin
            pf_rq <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fe_req.valid) begin
            pf_addr <= next_line;
        end
    end

endmodule

`default_nettype wire

// File: source/fe_types_pkg.sv
`default_nettype none

package fe_types_pkg;
    import mem_types_pkg::*;

    // Line buffer and miss entry sizing
    localparam int FB_NUM_SETS     = 8;
    localparam int FB_SET_W        = 3;
    localparam int FB_NUM_ENTS     = 4;
    localparam int FB_NUM_ENTS_LG2 = 2;
    localparam int FE_ID_W         = 4;
    localparam int INSTR_W         = 32;
    localparam int INSTR_BYTES_LG2 = 2;

    typedef logic [FE_ID_W-1:0]  t_fe_id;
    typedef logic [INSTR_W-1:0]  t_instr;
    typedef logic [FB_SET_W-1:0] t_setid;

    typedef struct packed {
        logic   valid;
        t_fe_id id;
        t_paddr addr;
    } t_fe_fb_req;

    typedef struct packed {
        logic   valid;
        t_fe_id id;
        t_paddr pc;
        t_instr instr;
    } t_fb_fe_rsp;

    // Held by an entry from allocation until it frees itself
    typedef struct packed {
        t_fe_fb_req req;
        logic       pf;
    } t_ent_static;

    typedef enum logic [1:0] {
        ENT_IDLE,
        ENT_IC_REQ,
        ENT_IC_WAIT,
        ENT_FE_RSP
    } t_ent_state;

    // Set index sits right above the line offset
    function automatic t_setid get_setid(input t_paddr a);
        return a[CL_OFFS_W +: FB_SET_W];
    endfunction

    function automatic t_instr instr_from_cl(input t_cl cl, input t_paddr a);
        return cl[a[CL_OFFS_W-1:INSTR_BYTES_LG2] * INSTR_W +: INSTR_W];
    endfunction

endpackage

`default_nettype wire

// File: source/mem_types_pkg.sv
`default_nettype none

package mem_types_pkg;

    // Line geometry
    localparam int PADDR_W   = 32;
    localparam int CL_BYTES  = 16;
    localparam int CL_OFFS_W = 4;
    localparam int MEM_ID_W  = 2;

    typedef logic [PADDR_W-1:0]    t_paddr;
    typedef logic [CL_BYTES*8-1:0] t_cl;
    typedef logic [MEM_ID_W-1:0]   t_mem_id;

    // Line request toward the instruction cache
    typedef struct packed {
        logic    valid;
        t_mem_id id;
        t_paddr  addr;
    } t_mem_req;

    typedef struct packed {
        logic    valid;
        t_mem_id id;
        t_cl     data;
    } t_mem_rsp;

    // Clear the byte offset within the line
    function automatic t_paddr cl_align(input t_paddr a);
        return {a[PADDR_W-1:CL_OFFS_W], {CL_OFFS_W{1'b0}}};
    endfunction

endpackage

`default_nettype wire
